/* Makefile */
# Verilator lint, simulation and clean for the host-side support logic

TOP := sms_host_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
common/sms_host_pkg.sv
common/sms_mem_pkg.sv
src/sms_clk_enables.sv
loader/cart_loader.sv
loader/cheat_code_collector.sv
backup/backup_sequencer.sv
src/sms_host_top.sv
dv/sms_host_props.sv
dv/sms_host_tb.sv

/* backup/backup_sequencer.sv */
`timescale 1ns/1ps
// Backup RAM sequencer
// Loads and saves battery RAM one sector at a time over the sector
// port, tracks unsaved writes and saves on OSD open with autosave
module backup_sequencer #(
	parameter int BK_SECTORS = 64
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_loading,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic [63:0]          img_size,
	input  logic                 osd_open,
	input  logic                 autosave,
	input  logic                 bk_load_req,
	input  logic                 bk_save_req,
	input  logic                 nvram_we,
	input  logic                 sd_ack,
	output sms_mem_pkg::sd_lba_t sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic                 bk_loading,
	output logic                 bk_busy,
	output logic                 bk_pending
);
	import sms_mem_pkg::*;

	localparam sd_lba_t LAST_LBA = sd_lba_t'(BK_SECTORS - 1);

	bk_state_e state;
	logic      bk_ena;
	logic      loading_q;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      load_lvl;
	logic      save_lvl;
	logic      load_start;
	logic      save_start;
	logic      auto_load;
	logic      seq_start;
	logic      ack_rise;
	logic      ack_fall;

	// Requests only count with a writable save image
	assign load_lvl   = bk_load_req && bk_ena;
	assign save_lvl   = (bk_save_req || (bk_pending && osd_open && autosave)) && bk_ena;
	assign load_start = load_lvl && !load_q;
	assign save_start = save_lvl && !save_q;
	// Save file comes in with the cartridge, pull it in afterwards
	assign auto_load  = loading_q && !cart_loading && (img_size != '0) && bk_ena;
	assign seq_start  = (state == BK_IDLE) && (load_start || save_start || auto_load);

	assign ack_rise = sd_ack && !ack_q;
	assign ack_fall = !sd_ack && ack_q;

	assign bk_busy    = (state != BK_IDLE);
	assign bk_loading = (state == BK_READ);

	//====================================================================
	// Enable and pending flag
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			loading_q  <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			if (cart_loading && !loading_q)
				bk_ena <= 1'b0;
			if (cart_loading && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
			if (seq_start)
				bk_pending <= 1'b0;
			else if (bk_ena && !osd_open && nvram_we)
				bk_pending <= 1'b1;
		end
	end

	//====================================================================
	// Sector sequence
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state  <= BK_IDLE;
			sd_lba <= '0;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			load_q <= load_lvl;
			save_q <= save_lvl;
			ack_q  <= sd_ack;
			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			case (state)
				BK_IDLE: begin
					if (load_start || auto_load) begin
						state  <= BK_READ;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
						sd_wr  <= 1'b0;
					end else if (save_start) begin
						state  <= BK_WRITE;
						sd_lba <= '0;
						sd_rd  <= 1'b0;
						sd_wr  <= 1'b1;
					end
				end
				BK_READ, BK_WRITE: begin
					// Sector finished on the ack fall
					if (ack_fall) begin
						if (sd_lba == LAST_LBA) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= (state == BK_READ);
							sd_wr  <= (state == BK_WRITE);
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

/* common/sms_host_pkg.sv */
// Host download bus definitions
// Types for the byte stream coming from the download host, the
// download index values and the layout of one cheat code record
package sms_host_pkg;

	// Widths of the download bus fields
	typedef logic [24:0] host_addr_t;
	typedef logic [7:0]  host_byte_t;
	typedef logic [7:0]  host_index_t;

	// One download bus sample, 43 bits
	typedef struct packed {
		logic        download;
		logic        wr;
		host_index_t index;
		host_addr_t  addr;
		host_byte_t  dout;
	} host_wr_t;

	//====================================================================
	// Download index values
	//====================================================================

	// Cartridge types, only the low five index bits are compared
	parameter logic [4:0] IDX_SMS = 5'd1;
	parameter logic [4:0] IDX_GG  = 5'd2;

	// Cheat list, every other index is a cartridge image
	parameter host_index_t IDX_CHEAT = 8'd255;

	//====================================================================
	// Cheat record
	//====================================================================

	// Each field is filled from four little-endian download bytes,
	// flags first, replace last
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

/* common/sms_mem_pkg.sv */
// Memory side definitions
// ROM write stream, backup sector port types, divider and header
// constants, and the backup sequencer states
package sms_mem_pkg;

	// ROM byte address, 4 MB space
	typedef logic [21:0] rom_addr_t;

	// One ROM write offer, a new byte is signalled by a toggle flip
	typedef struct packed {
		logic        toggle;
		rom_addr_t   addr;
		logic [7:0]  data;
	} rom_wr_t;

	// Sector port
	typedef logic [31:0] sd_lba_t;
	typedef logic [8:0]  sd_buf_addr_t;

	// System clock cycles per clock-enable period
	parameter int CE_PERIOD = 30;

	// Optional copier header in front of some images
	parameter int HDR_SIZE = 512;

	// Backup RAM transfer direction
	typedef enum logic [1:0] {
		BK_IDLE  = 2'd0,
		BK_READ  = 2'd1,
		BK_WRITE = 2'd2
	} bk_state_e;

endpackage

/* dv/sms_host_props.sv */
`timescale 1ns/1ps
// Handshake properties
// Sector request exclusivity, host hold-off and the cheat strobe
module sms_host_props (
	input logic                      clk_sys,
	input logic                      RESET,
	input logic                      host_wr,
	input logic                      host_wait,
	input logic                      sd_rd,
	input logic                      sd_wr,
	input sms_mem_pkg::bk_state_e    bk_state,
	input logic                      cheat_valid
);
	import sms_mem_pkg::*;

	// Only one transfer direction at a time
	req_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr both high");

	rd_in_read: assert property (@(posedge clk_sys) disable iff (RESET)
		sd_rd |-> (bk_state == BK_READ))
		else $error("sd_rd outside the read sequence");

	wr_in_write: assert property (@(posedge clk_sys) disable iff (RESET)
		sd_wr |-> (bk_state == BK_WRITE))
		else $error("sd_wr outside the write sequence");

	host_held_off: assert property (@(posedge clk_sys) disable iff (RESET)
		host_wr |-> !host_wait)
		else $error("host write while host_wait is high");

	valid_single: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid longer than one cycle");

endmodule

bind backup_sequencer sms_host_props i_seq_props (
	.clk_sys (clk_sys), .RESET (RESET), .host_wr (1'b0), .host_wait (1'b0),
	.sd_rd (sd_rd), .sd_wr (sd_wr), .bk_state (state), .cheat_valid (1'b0)
);

bind cart_loader sms_host_props i_loader_props (
	.clk_sys (clk_sys), .RESET (RESET), .host_wr (host.wr), .host_wait (host_wait),
	.sd_rd (1'b0), .sd_wr (1'b0), .bk_state (sms_mem_pkg::BK_IDLE), .cheat_valid (1'b0)
);

bind cheat_code_collector sms_host_props i_cheat_props (
	.clk_sys (clk_sys), .RESET (RESET), .host_wr (1'b0), .host_wait (1'b0),
	.sd_rd (1'b0), .sd_wr (1'b0), .bk_state (sms_mem_pkg::BK_IDLE),
	.cheat_valid (cheat_valid)
);

/* dv/sms_host_tb.sv */
`timescale 1ns/1ps
// Testbench for the host-side support logic
// Drives cartridge, cheat and backup traffic into the top level with
// ROM memory and sector host models, and checks every response
module sms_host_tb;
	import sms_host_pkg::*;
	import sms_mem_pkg::*;

	localparam int BK_SECTORS = 64;
	// All download bytes at up to six cycles each, three sector
	// sequences at up to eight cycles per sector, plus slack
	localparam int TIMEOUT_CYCLES = 2240 * 6 + 3 * BK_SECTORS * 8 + 5000;
	localparam int WAIT_LIMIT = 10;

	logic        clk_sys;
	logic        RESET;
	host_wr_t    host;
	logic        rom_ack;
	rom_addr_t   rom_rd_addr;
	logic        img_mounted;
	logic        img_readonly;
	logic [63:0] img_size;
	logic        osd_open;
	logic        autosave;
	logic        bk_load_req;
	logic        bk_save_req;
	logic        nvram_we;
	logic        sd_ack;
	logic        ce_cpu;
	logic        ce_vdp;
	logic        ce_pix;
	logic        ce_sp;
	rom_wr_t     rom_wr;
	logic        host_wait;
	rom_addr_t   rom_map_addr;
	logic        is_gg;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;
	sd_lba_t     sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        bk_loading;
	logic        bk_busy;
	logic        bk_pending;

	int         seed = 32'hcb68_0c23;
	int         err_cnt = 0;
	int         check_cnt = 0;
	int         test_cnt = 0;
	int         valid_cnt = 0;
	int         clear_cnt = 0;
	logic       valid_prev = 1'b0;
	rom_addr_t  rom_log_addr[$];
	host_byte_t rom_log_data[$];
	sd_lba_t    sect_lba[$];
	logic       sect_wr[$];

	sms_host_top #(
		.BK_SECTORS (BK_SECTORS)
	) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

	//====================================================================
	// Helpers and compare tasks
	//====================================================================

	// Every drive and sample happens 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		err_cnt++;
	endtask

	task automatic check_byte(input string name, input host_byte_t got, input host_byte_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_lba(input string name, input sd_lba_t got, input sd_lba_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_code(input string name, input cheat_code_t got, input cheat_code_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s: got %b, expected %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		check_cnt++;
		if (got != exp) begin
			$display("MISMATCH t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int base);
		test_cnt++;
		$display("Test %s: %s (%0d errors)", name, (err_cnt == base) ? "ok" : "FAILED",
		         err_cnt - base);
	endtask

	// Image fill, mixes both address bytes into the data
	function automatic host_byte_t pattern_byte(input int a, input host_byte_t salt);
		return host_byte_t'(a) ^ (host_byte_t'(a >> 8) * 8'd37) ^ salt;
	endfunction

	//====================================================================
	// Models and protocol monitor
	//====================================================================

	// ROM memory, acks each toggle flip after 1 to 4 cycles
	initial begin : rom_model
		logic last_toggle;
		int   delay;
		rom_ack = 1'b0;
		last_toggle = 1'b0;
		forever begin
			next_cycle();
			if (!RESET && (rom_wr.toggle !== last_toggle)) begin
				last_toggle = rom_wr.toggle;
				rom_log_addr.push_back(rom_wr.addr);
				rom_log_data.push_back(rom_wr.data);
				delay = 1 + int'($unsigned($random(seed)) % 4);
				repeat (delay) next_cycle();
				rom_ack = last_toggle;
			end
		end
	end

	// Sector host, one ack pulse per request after 0 to 2 cycles
	initial begin : sector_model
		int delay;
		sd_ack = 1'b0;
		forever begin
			next_cycle();
			if (!RESET && (sd_rd || sd_wr)) begin
				sect_lba.push_back(sd_lba);
				sect_wr.push_back(sd_wr);
				delay = int'($unsigned($random(seed)) % 3);
				repeat (delay) next_cycle();
				sd_ack = 1'b1;
				next_cycle();
				sd_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (sd_rd && sd_wr)
				report_error("sd_rd and sd_wr are high together");
			if (host.wr && host_wait)
				report_error("host wrote while host_wait was high");
			if (cheat_valid && valid_prev)
				report_error("cheat_valid stayed high for more than one cycle");
			if (cheat_valid)
				valid_cnt++;
			if (cheat_clear)
				clear_cnt++;
			valid_prev = cheat_valid;
		end
	end

	//====================================================================
	// Host download and sequence helpers
	//====================================================================

	task automatic write_cart_byte(input int a, input host_byte_t d);
		int n;
		host.addr = host_addr_t'(a);
		host.dout = d;
		host.wr = 1'b1;
		next_cycle();
		host.wr = 1'b0;
		if (host_wait !== 1'b1)
			report_error("host_wait did not rise after a cartridge write");
		n = 0;
		while (host_wait && (n < WAIT_LIMIT)) begin
			next_cycle();
			n++;
		end
		if (host_wait !== 1'b0)
			report_error("host_wait was not released after the ROM ack");
	endtask

	task automatic run_download(input host_index_t idx, input int nbytes, input host_byte_t salt);
		rom_log_addr.delete();
		rom_log_data.delete();
		host.index = idx;
		host.download = 1'b1;
		next_cycle();
		for (int i = 0; i < nbytes; i++)
			write_cart_byte(i, pattern_byte(i, salt));
		host.download = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic verify_rom_log(input int nbytes, input host_byte_t salt);
		check_count("ROM writes", rom_log_addr.size(), nbytes);
		for (int i = 0; (i < nbytes) && (i < rom_log_addr.size()); i++) begin
			check_rom_addr("rom_wr.addr", rom_log_addr[i], rom_addr_t'(i));
			check_byte("rom_wr.data", rom_log_data[i], pattern_byte(i, salt));
		end
	endtask

	// Request already issued, sector logs cleared before it
	task automatic expect_sequence(input logic is_write);
		int n;
		n = 0;
		while (!(sd_rd || sd_wr) && (n < 2)) begin
			next_cycle();
			n++;
		end
		if (!(sd_rd || sd_wr))
			report_error("no sector request within two cycles of the backup request");
		check_bit("bk_busy", bk_busy, 1'b1);
		check_bit("bk_loading", bk_loading, !is_write);
		n = 0;
		while (bk_busy && (n < BK_SECTORS * 10)) begin
			next_cycle();
			n++;
		end
		if (bk_busy !== 1'b0)
			report_error("bk_busy did not fall after the sector sequence");
		check_count("sector requests", sect_lba.size(), BK_SECTORS);
		for (int i = 0; i < sect_lba.size(); i++) begin
			check_lba("sd_lba", sect_lba[i], sd_lba_t'(i));
			check_bit("sd_wr at request", sect_wr[i], is_write);
		end
	endtask

	//====================================================================
	// Tests
	//====================================================================

	task automatic count_clock_enables();
		int base;
		int n_sp;
		int n_vdp;
		int n_pix;
		int n_cpu;
		base = err_cnt;
		// Two windows at different divider phases
		for (int w = 0; w < 2; w++) begin
			repeat (CE_PERIOD + 7) next_cycle();
			n_sp = 0;
			n_vdp = 0;
			n_pix = 0;
			n_cpu = 0;
			for (int i = 0; i < CE_PERIOD; i++) begin
				next_cycle();
				n_sp += int'(ce_sp);
				n_vdp += int'(ce_vdp);
				n_pix += int'(ce_pix);
				n_cpu += int'(ce_cpu);
			end
			check_count("ce_sp pulses", n_sp, 15);
			check_count("ce_vdp pulses", n_vdp, 6);
			check_count("ce_pix pulses", n_pix, 3);
			check_count("ce_cpu pulses", n_cpu, 2);
		end
		finish_test("clock enables", base);
	endtask

	task automatic load_gg_then_sms();
		int base;
		base = err_cnt;
		run_download(8'd2, 64, 8'h11);
		verify_rom_log(64, 8'h11);
		check_bit("is_gg", is_gg, 1'b1);
		run_download(8'd1, 64, 8'h22);
		verify_rom_log(64, 8'h22);
		check_bit("is_gg", is_gg, 1'b0);
		finish_test("cartridge download", base);
	endtask

	task automatic map_rom_reads();
		int        base;
		rom_addr_t a;
		base = err_cnt;
		// Image of 64 bytes is still loaded
		for (int i = 0; i < 8; i++) begin
			a = rom_addr_t'($random(seed));
			rom_rd_addr = a;
			next_cycle();
			check_rom_addr("rom_map_addr", rom_map_addr, a & rom_addr_t'(63));
		end
		// 512-byte header in front of a 64-byte image
		run_download(8'd1, 576, 8'h33);
		verify_rom_log(576, 8'h33);
		for (int i = 0; i < 8; i++) begin
			a = rom_addr_t'($random(seed));
			rom_rd_addr = a;
			next_cycle();
			check_rom_addr("rom_map_addr", rom_map_addr,
			               (a + rom_addr_t'(512)) & rom_addr_t'(63));
		end
		finish_test("ROM read mapping", base);
	endtask

	task automatic collect_cheat_record();
		int          base;
		int          valid_start;
		int          clear_start;
		host_byte_t  b[16];
		logic [31:0] f[4];
		cheat_code_t exp;
		base = err_cnt;
		valid_start = valid_cnt;
		clear_start = clear_cnt;
		for (int k = 0; k < 4; k++)
			f[k] = '0;
		host.index = IDX_CHEAT;
		host.download = 1'b1;
		next_cycle();
		for (int k = 0; k < 16; k++) begin
			b[k] = host_byte_t'($random(seed));
			host.addr = host_addr_t'(k);
			host.dout = b[k];
			host.wr = 1'b1;
			next_cycle();
			host.wr = 1'b0;
			if (k == 15)
				check_bit("cheat_valid", cheat_valid, 1'b1);
			next_cycle();
		end
		host.download = 1'b0;
		next_cycle();
		// Byte k lands in field k/4, lowest byte first
		for (int k = 0; k < 16; k++)
			f[k / 4][8 * (k % 4) +: 8] = b[k];
		exp = '{flags: f[0], address: f[1], compare: f[2], replace: f[3]};
		check_code("cheat_code", cheat_code, exp);
		check_count("cheat_valid pulses", valid_cnt - valid_start, 1);
		check_count("cheat_clear pulses", clear_cnt - clear_start, 1);
		finish_test("cheat record", base);
	endtask

	task automatic transfer_backup();
		int base;
		base = err_cnt;
		// Writable save image mounted while the cartridge loads
		img_mounted = 1'b1;
		img_readonly = 1'b0;
		img_size = 64'd0;
		run_download(8'd1, 1536, 8'h5c);
		img_mounted = 1'b0;
		verify_rom_log(1536, 8'h5c);
		sect_lba.delete();
		sect_wr.delete();
		bk_save_req = 1'b1;
		next_cycle();
		bk_save_req = 1'b0;
		expect_sequence(1'b1);
		sect_lba.delete();
		sect_wr.delete();
		bk_load_req = 1'b1;
		next_cycle();
		bk_load_req = 1'b0;
		expect_sequence(1'b0);
		finish_test("backup save and load", base);
	endtask

	task automatic autosave_on_osd();
		int base;
		base = err_cnt;
		nvram_we = 1'b1;
		next_cycle();
		nvram_we = 1'b0;
		next_cycle();
		check_bit("bk_pending", bk_pending, 1'b1);
		sect_lba.delete();
		sect_wr.delete();
		autosave = 1'b1;
		osd_open = 1'b1;
		next_cycle();
		expect_sequence(1'b1);
		check_bit("bk_pending", bk_pending, 1'b0);
		osd_open = 1'b0;
		autosave = 1'b0;
		next_cycle();
		finish_test("autosave", base);
	endtask

	initial begin
		RESET = 1'b1;
		host = '0;
		rom_rd_addr = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		osd_open = 1'b0;
		autosave = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		nvram_we = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		count_clock_enables();
		load_gg_then_sms();
		map_rom_reads();
		collect_cheat_record();
		transfer_backup();
		autosave_on_osd();
		$display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* loader/cart_loader.sv */
`timescale 1ns/1ps
// Cartridge loader
// Turns host download bytes into a toggle and acknowledge write stream
// towards ROM memory, holding the host off with a wait level, and maps
// console ROM reads through the learned size mask
module cart_loader (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  sms_host_pkg::host_wr_t host,
	input  logic                   rom_ack,
	input  sms_mem_pkg::rom_addr_t rom_rd_addr,
	output sms_mem_pkg::rom_wr_t   rom_wr,
	output logic                   host_wait,
	output sms_mem_pkg::rom_addr_t rom_map_addr,
	output logic                   cart_loading,
	output logic                   is_gg
);
	import sms_host_pkg::*;
	import sms_mem_pkg::*;

	localparam rom_addr_t HDR_OFS = rom_addr_t'(HDR_SIZE);
	localparam int        HDR_BIT = $clog2(HDR_SIZE);

	logic       loading_q;
	logic       cart_wr;
	logic       wr_done;
	logic       wr_toggle;
	rom_addr_t  wr_addr;
	host_byte_t wr_data;
	rom_addr_t  wr_ofs;
	rom_addr_t  size_mask;
	rom_addr_t  hdr_mask;
	logic       last_hdr_bit;
	logic       hdr_skip;

	assign cart_loading = host.download && (host.index != IDX_CHEAT);
	assign cart_wr      = host.wr && cart_loading;
	assign wr_ofs       = rom_addr_t'(host.addr);

	// Memory has caught up with the last offer
	assign wr_done = host_wait && (rom_ack == wr_toggle);

	assign rom_wr = '{toggle: wr_toggle, addr: wr_addr, data: wr_data};

	//====================================================================
	// Write stream and host hold-off
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			loading_q <= 1'b0;
			host_wait <= 1'b0;
			wr_toggle <= 1'b0;
			hdr_skip  <= 1'b0;
			is_gg     <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			if (cart_wr) begin
				host_wait <= 1'b1;
				wr_toggle <= ~wr_toggle;
			end else if (wr_done) begin
				host_wait <= 1'b0;
			end
			// Header present when the image size has bit 9 set
			if (loading_q && !cart_loading)
				hdr_skip <= last_hdr_bit;
			if (cart_wr && (host.addr == '0))
				is_gg <= (host.index[4:0] == IDX_GG);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_loading && !loading_q)
			wr_addr <= '0;
		else if (wr_done && !cart_wr)
			wr_addr <= wr_addr + 1'b1;
		if (cart_wr)
			wr_data <= host.dout;
	end

	//====================================================================
	// Size masks
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			size_mask    <= (host.addr == '0) ? '0 : size_mask | wr_ofs;
			// Mask as seen with the header stripped off
			hdr_mask     <= (host.addr == host_addr_t'(HDR_SIZE)) ?
			                '0 : hdr_mask | (wr_ofs - HDR_OFS);
			last_hdr_bit <= host.addr[HDR_BIT];
		end
	end

	// Console read mapping
	always_comb begin
		if (hdr_skip)
			rom_map_addr = (rom_rd_addr + HDR_OFS) & hdr_mask;
		else
			rom_map_addr = rom_rd_addr & size_mask;
	end

endmodule

/* loader/cheat_code_collector.sv */
`timescale 1ns/1ps
// Cheat code collector
// Assembles sixteen bytes of the cheat download into one code record
// and flags each completed record with a one-cycle pulse
module cheat_code_collector (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  sms_host_pkg::host_wr_t    host,
	output sms_host_pkg::cheat_code_t cheat_code,
	output logic                      cheat_valid,
	output logic                      cheat_clear
);
	import sms_host_pkg::*;

	logic       code_wr;
	logic [3:0] byte_sel;
	logic [4:0] bit_ofs;

	assign code_wr  = host.download && host.wr && (host.index == IDX_CHEAT);
	assign byte_sel = host.addr[3:0];

	// Little-endian byte position inside the selected field
	assign bit_ofs = {byte_sel[1:0], 3'b000};

	// Record payload
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (byte_sel[3:2])
				2'd0: cheat_code.flags[bit_ofs +: 8]   <= host.dout;
				2'd1: cheat_code.address[bit_ofs +: 8] <= host.dout;
				2'd2: cheat_code.compare[bit_ofs +: 8] <= host.dout;
				default: cheat_code.replace[bit_ofs +: 8] <= host.dout;
			endcase
		end
	end

	//====================================================================
	// Record strobes
	//====================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last byte of a record lands with this pulse
			cheat_valid <= code_wr && (byte_sel == 4'hF);
			// Any new download restarts the cheat list
			cheat_clear <= host.download && host.wr && (host.addr == '0);
		end
	end

endmodule

/* src/sms_clk_enables.sv */
`timescale 1ns/1ps
// Clock-enable generator
// Divides clk_sys by thirty into registered one-cycle strobes for the
// CPU, the VDP, the pixel pipeline and the sound chip
module sms_clk_enables (
	input  logic clk_sys,
	input  logic RESET,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import sms_mem_pkg::*;

	localparam int CNT_W = $clog2(CE_PERIOD);

	logic [CNT_W-1:0] div_cnt;
	logic             vdp_hit;
	logic             pix_hit;
	logic             cpu_hit;

	// Phase decode, VDP every fifth count, pixel every tenth
	always_comb begin
		vdp_hit = 1'b0;
		pix_hit = 1'b0;
		cpu_hit = 1'b0;
		case (div_cnt)
			CNT_W'(4), CNT_W'(14): vdp_hit = 1'b1;
			CNT_W'(9): begin
				vdp_hit = 1'b1;
				pix_hit = 1'b1;
				cpu_hit = 1'b1;
			end
			CNT_W'(19), CNT_W'(29): begin
				vdp_hit = 1'b1;
				pix_hit = 1'b1;
			end
			// Second CPU phase, fifteen counts after the first
			CNT_W'(24): begin
				vdp_hit = 1'b1;
				cpu_hit = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div_cnt <= '0;
			ce_cpu  <= 1'b0;
			ce_vdp  <= 1'b0;
			ce_pix  <= 1'b0;
			ce_sp   <= 1'b0;
		end else begin
			div_cnt <= (div_cnt == CNT_W'(CE_PERIOD - 1)) ? '0 : div_cnt + 1'b1;
			// Sound runs at half the system clock
			ce_sp   <= div_cnt[0];
			ce_vdp  <= vdp_hit;
			ce_pix  <= pix_hit;
			ce_cpu  <= cpu_hit;
		end
	end

endmodule

/* src/sms_host_top.sv */
`timescale 1ns/1ps
// Host-side support logic of the console core
// Clock enables, cartridge loader, cheat collector and backup RAM
// sequencer between the download and storage host and the console
module sms_host_top #(
	parameter int BK_SECTORS = 64
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	// Download host and ROM memory
	input  sms_host_pkg::host_wr_t    host,
	input  logic                      rom_ack,
	input  sms_mem_pkg::rom_addr_t    rom_rd_addr,
	// Storage host and console
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [63:0]               img_size,
	input  logic                      osd_open,
	input  logic                      autosave,
	input  logic                      bk_load_req,
	input  logic                      bk_save_req,
	input  logic                      nvram_we,
	input  logic                      sd_ack,
	output logic                      ce_cpu,
	output logic                      ce_vdp,
	output logic                      ce_pix,
	output logic                      ce_sp,
	output sms_mem_pkg::rom_wr_t      rom_wr,
	output logic                      host_wait,
	output sms_mem_pkg::rom_addr_t    rom_map_addr,
	output logic                      is_gg,
	output sms_host_pkg::cheat_code_t cheat_code,
	output logic                      cheat_valid,
	output logic                      cheat_clear,
	output sms_mem_pkg::sd_lba_t      sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic                      bk_loading,
	output logic                      bk_busy,
	output logic                      bk_pending
);

	// Cartridge download in progress
	logic cart_loading;

	sms_clk_enables i_clk_enables (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader i_cart_loader (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.host         (host),
		.rom_ack      (rom_ack),
		.rom_rd_addr  (rom_rd_addr),
		.rom_wr       (rom_wr),
		.host_wait    (host_wait),
		.rom_map_addr (rom_map_addr),
		.cart_loading (cart_loading),
		.is_gg        (is_gg)
	);

	cheat_code_collector i_cheat_collector (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.host        (host),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	backup_sequencer #(
		.BK_SECTORS (BK_SECTORS)
	) i_backup_seq (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_loading (cart_loading),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.osd_open     (osd_open),
		.autosave     (autosave),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.nvram_we     (nvram_we),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_loading   (bk_loading),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending)
	);

endmodule
